// File: src/cpu_pkg.sv
package cpu_pkg;

	////////////////////////////////////////////////////////////////////////////
	// datapath sizes
	////////////////////////////////////////////////////////////////////////////
	localparam int DATA_W = 32;
	localparam int REG_AW = 5;

	// unit selector from decode
	localparam logic [2:0] SEL_NOP   = 3'd0;
	localparam logic [2:0] SEL_LOGIC = 3'd1;
	localparam logic [2:0] SEL_SHIFT = 3'd2;
	localparam logic [2:0] SEL_MOVE  = 3'd3;
	localparam logic [2:0] SEL_ARITH = 3'd4;

	////////////////////////////////////////////////////////////////////////////
	// operation codes, grouped by selector
	////////////////////////////////////////////////////////////////////////////
	localparam logic [7:0] OP_AND   = 8'b0010_0100;
	localparam logic [7:0] OP_OR    = 8'b0010_0101;
	localparam logic [7:0] OP_XOR   = 8'b0010_0110;
	localparam logic [7:0] OP_NOR   = 8'b0010_0111;
	localparam logic [7:0] OP_LUI   = 8'b0000_1111;

	localparam logic [7:0] OP_SLL   = 8'b0000_0100;
	localparam logic [7:0] OP_SRL   = 8'b0000_0110;
	localparam logic [7:0] OP_SRA   = 8'b0000_0111;

	localparam logic [7:0] OP_MOVZ  = 8'b0000_1010;
	localparam logic [7:0] OP_MOVN  = 8'b0000_1011;
	localparam logic [7:0] OP_MFHI  = 8'b0001_0000;
	localparam logic [7:0] OP_MTHI  = 8'b0001_0001;
	localparam logic [7:0] OP_MFLO  = 8'b0001_0010;
	localparam logic [7:0] OP_MTLO  = 8'b0001_0011;

	localparam logic [7:0] OP_ADD   = 8'b0010_0000;
	localparam logic [7:0] OP_ADDU  = 8'b0010_0001;
	localparam logic [7:0] OP_SUB   = 8'b0010_0010;
	localparam logic [7:0] OP_SUBU  = 8'b0010_0011;
	localparam logic [7:0] OP_SLT   = 8'b0010_1010;
	localparam logic [7:0] OP_SLTU  = 8'b0010_1011;
	localparam logic [7:0] OP_CLZ   = 8'b1110_0000;
	localparam logic [7:0] OP_CLO   = 8'b1110_0001;
	localparam logic [7:0] OP_MUL   = 8'b0000_0010;
	localparam logic [7:0] OP_MULT  = 8'b0001_1000;
	localparam logic [7:0] OP_MULTU = 8'b0001_1001;

	////////////////////////////////////////////////////////////////////////////
	// stage records
	////////////////////////////////////////////////////////////////////////////

	// one decoded instruction per cycle
	typedef struct packed {
		logic [2:0]        alusel;
		logic [7:0]        aluop;
		logic [DATA_W-1:0] reg1;
		logic [DATA_W-1:0] reg2;
		logic              we;
		logic [REG_AW-1:0] waddr;
	} id_ex_t;

	// general register write
	typedef struct packed {
		logic              we;
		logic [REG_AW-1:0] waddr;
		logic [DATA_W-1:0] wdata;
	} gpr_wr_t;

	typedef struct packed {
		logic [DATA_W-1:0] hi;
		logic [DATA_W-1:0] lo;
	} hilo_t;

	// hi/lo writes always carry both halves
	typedef struct packed {
		logic  whilo;
		hilo_t hilo;
	} hilo_wr_t;

endpackage

// File: src/lead_count.sv
`timescale 1ns/1ns

module lead_count import cpu_pkg::*; (
	input  logic [DATA_W-1:0] word,
	input  logic              ones,
	output logic [5:0]        count
);

	logic hit;

	// scan from the msb, stop at the first bit that differs from ones
	always_comb begin
		count = 6'd32;
		hit = 1'b0;
		for (int i = DATA_W - 1; i >= 0; i--) begin
			if (!hit && (word[i] != ones)) begin
				count = 6'(DATA_W - 1 - i);
				hit = 1'b1;
			end
		end
	end

endmodule

// File: src/signed_mult.sv
`timescale 1ns/1ns

module signed_mult import cpu_pkg::*; (
	input  logic [DATA_W-1:0]   a,
	input  logic [DATA_W-1:0]   b,
	input  logic                is_signed,
	output logic [2*DATA_W-1:0] product
);

	logic                a_neg;
	logic                b_neg;
	logic [DATA_W-1:0]   a_mag;
	logic [DATA_W-1:0]   b_mag;
	logic [2*DATA_W-1:0] mag_product;

	// sign-magnitude: multiply magnitudes, fix the sign afterwards
	assign a_neg = is_signed & a[DATA_W-1];
	assign b_neg = is_signed & b[DATA_W-1];

	// the most negative word maps to 2^31, still fits unsigned
	assign a_mag = a_neg ? (~a + 1'b1) : a;
	assign b_mag = b_neg ? (~b + 1'b1) : b;

	assign mag_product = {{DATA_W{1'b0}}, a_mag} * {{DATA_W{1'b0}}, b_mag};

	assign product = (a_neg ^ b_neg) ? (~mag_product + 1'b1) : mag_product;

endmodule

// File: src/ex_stage.sv
`timescale 1ns/1ns

module ex_stage import cpu_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,
	input  id_ex_t   id,
	input  hilo_t    hilo_fwd,
	output gpr_wr_t  ex_gpr,
	output hilo_wr_t ex_hilo
);

	logic [DATA_W-1:0]   logic_res;
	logic [DATA_W-1:0]   shift_res;
	logic [DATA_W-1:0]   move_res;
	logic                move_ok;
	logic [DATA_W-1:0]   arith_res;
	logic                arith_ok;

	logic                is_sub;
	logic [DATA_W-1:0]   addend;
	logic [DATA_W:0]     sum_ext;
	logic [DATA_W-1:0]   sum;
	logic                overflow;
	logic                lt_signed;
	logic                lt_unsigned;

	logic [5:0]          lead;
	logic [2*DATA_W-1:0] product;

	gpr_wr_t             gpr_next;
	hilo_wr_t            hilo_next;

	lead_count lead_count_i (
		.word  (id.reg1),
		.ones  (id.aluop == OP_CLO),
		.count (lead)
	);

	signed_mult signed_mult_i (
		.a         (id.reg1),
		.b         (id.reg2),
		.is_signed (id.aluop != OP_MULTU),
		.product   (product)
	);

	//////////////////////////////////////////////////////////////////////////
	// shared adder, subtract as a + ~b + 1
	//////////////////////////////////////////////////////////////////////////
	assign is_sub = (id.aluop == OP_SUB) || (id.aluop == OP_SUBU) ||
			(id.aluop == OP_SLT) || (id.aluop == OP_SLTU);
	assign addend  = is_sub ? ~id.reg2 : id.reg2;
	assign sum_ext = {1'b0, id.reg1} + {1'b0, addend} + {{DATA_W{1'b0}}, is_sub};
	assign sum     = sum_ext[DATA_W-1:0];

	// signed overflow, operands alike in sign but sum differs
	assign overflow = (id.reg1[DATA_W-1] == addend[DATA_W-1]) &&
			  (sum[DATA_W-1] != id.reg1[DATA_W-1]);

	assign lt_signed   = sum[DATA_W-1] ^ overflow;
	// no carry out on a - b means borrow
	assign lt_unsigned = ~sum_ext[DATA_W];

	//////////////////////////////////////////////////////////////////////////
	// per-group results
	//////////////////////////////////////////////////////////////////////////
	always_comb begin
		case (id.aluop)
			OP_AND:  logic_res = id.reg1 & id.reg2;
			OP_OR:   logic_res = id.reg1 | id.reg2;
			OP_XOR:  logic_res = id.reg1 ^ id.reg2;
			OP_NOR:  logic_res = ~(id.reg1 | id.reg2);
			OP_LUI:  logic_res = {id.reg2[15:0], 16'd0};
			default: logic_res = '0;
		endcase
	end

	// shift amount from reg1, data from reg2
	always_comb begin
		case (id.aluop)
			OP_SLL:  shift_res = id.reg2 << id.reg1[4:0];
			OP_SRL:  shift_res = id.reg2 >> id.reg1[4:0];
			OP_SRA:  shift_res = $signed(id.reg2) >>> id.reg1[4:0];
			default: shift_res = '0;
		endcase
	end

	always_comb begin
		move_ok = 1'b1;
		case (id.aluop)
			OP_MOVZ: begin
				move_res = id.reg1;
				move_ok = (id.reg2 == '0);
			end
			OP_MOVN: begin
				move_res = id.reg1;
				move_ok = (id.reg2 != '0);
			end
			OP_MFHI: move_res = hilo_fwd.hi;
			OP_MFLO: move_res = hilo_fwd.lo;
			default: move_res = '0;
		endcase
	end

	always_comb begin
		arith_ok = 1'b1;
		case (id.aluop)
			OP_ADD, OP_SUB: begin
				arith_res = sum;
				arith_ok = ~overflow;
			end
			OP_ADDU, OP_SUBU: arith_res = sum;
			OP_SLT:           arith_res = DATA_W'(lt_signed);
			OP_SLTU:          arith_res = DATA_W'(lt_unsigned);
			OP_CLZ, OP_CLO:   arith_res = DATA_W'(lead);
			OP_MUL:           arith_res = product[DATA_W-1:0];
			default:          arith_res = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////////
	// writes toward memory stage
	//////////////////////////////////////////////////////////////////////////
	always_comb begin
		gpr_next.waddr = id.waddr;
		case (id.alusel)
			SEL_LOGIC: begin
				gpr_next.we = id.we;
				gpr_next.wdata = logic_res;
			end
			SEL_SHIFT: begin
				gpr_next.we = id.we;
				gpr_next.wdata = shift_res;
			end
			SEL_MOVE: begin
				gpr_next.we = id.we & move_ok;
				gpr_next.wdata = move_res;
			end
			SEL_ARITH: begin
				gpr_next.we = id.we & arith_ok;
				gpr_next.wdata = arith_res;
			end
			default: begin
				gpr_next.we = id.we;
				gpr_next.wdata = '0;
			end
		endcase
	end

	// mthi/mtlo keep the newest value of the other half
	always_comb begin
		hilo_next = '0;
		if (id.alusel == SEL_MOVE && id.aluop == OP_MTHI) begin
			hilo_next.whilo = 1'b1;
			hilo_next.hilo.hi = id.reg1;
			hilo_next.hilo.lo = hilo_fwd.lo;
		end else if (id.alusel == SEL_MOVE && id.aluop == OP_MTLO) begin
			hilo_next.whilo = 1'b1;
			hilo_next.hilo.hi = hilo_fwd.hi;
			hilo_next.hilo.lo = id.reg1;
		end else if (id.alusel == SEL_ARITH &&
				(id.aluop == OP_MULT || id.aluop == OP_MULTU)) begin
			hilo_next.whilo = 1'b1;
			hilo_next.hilo = product;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			ex_gpr <= '0;
			ex_hilo <= '0;
		end else begin
			ex_gpr <= gpr_next;
			ex_hilo <= hilo_next;
		end
	end

endmodule

// File: src/hilo_pipe.sv
`timescale 1ns/1ns

module hilo_pipe import cpu_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,
	input  gpr_wr_t  ex_gpr,
	input  hilo_wr_t ex_hilo,
	output gpr_wr_t  wb,
	output hilo_t    hilo,
	output hilo_t    hilo_fwd
);

	gpr_wr_t  mem_gpr;
	hilo_wr_t mem_hilo;
	hilo_t    hilo_reg;

	////////////////////////////////////////////////////////////////////////////
	// memory to writeback latch
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			mem_gpr <= '0;
			mem_hilo <= '0;
		end else begin
			mem_gpr <= ex_gpr;
			mem_hilo <= ex_hilo;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// architectural hi/lo
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			hilo_reg <= '0;
		end else if (mem_hilo.whilo) begin
			hilo_reg <= mem_hilo.hilo;
		end
	end

	// newest first: execute reg, then latch, then architectural
	always_comb begin
		if (ex_hilo.whilo) begin
			hilo_fwd = ex_hilo.hilo;
		end else if (mem_hilo.whilo) begin
			hilo_fwd = mem_hilo.hilo;
		end else begin
			hilo_fwd = hilo_reg;
		end
	end

	assign wb = mem_gpr;
	assign hilo = hilo_reg;

endmodule

// File: src/exec_top.sv
`timescale 1ns/1ns

module exec_top import cpu_pkg::*; (
	input  logic    clk,
	input  logic    reset_n,
	input  id_ex_t  id,
	output gpr_wr_t wb,
	output hilo_t   hilo
);

	gpr_wr_t  ex_gpr;
	hilo_wr_t ex_hilo;
	hilo_t    hilo_fwd;

	////////////////////////////////////////////////////////////////////////////
	// execute, then memory/writeback with hi/lo
	////////////////////////////////////////////////////////////////////////////
	ex_stage ex_stage_i (
		.clk      (clk),
		.reset_n  (reset_n),
		.id       (id),
		.hilo_fwd (hilo_fwd),
		.ex_gpr   (ex_gpr),
		.ex_hilo  (ex_hilo)
	);

	// forwarded hi/lo loops back into execute
	hilo_pipe hilo_pipe_i (
		.clk      (clk),
		.reset_n  (reset_n),
		.ex_gpr   (ex_gpr),
		.ex_hilo  (ex_hilo),
		.wb       (wb),
		.hilo     (hilo),
		.hilo_fwd (hilo_fwd)
	);

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

endmodule

// File: bench/exec_tb.sv
`timescale 1ns/1ns

module exec_tb import cpu_pkg::*; ();

	localparam int NUM_INSTR    = 3000;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 8;
	localparam int WAIT_LIMIT   = 10;

	// logic 0-4, shift 5-7, move 8-13 and arith 14-24 by table index
	localparam logic [7:0] OP_TABLE [25] = '{
		OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI,
		OP_SLL, OP_SRL, OP_SRA,
		OP_MOVZ, OP_MOVN, OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
		OP_CLZ, OP_CLO, OP_MUL, OP_MULT, OP_MULTU
	};

	logic    clk;
	logic    reset_n;
	id_ex_t  id;
	gpr_wr_t wb;
	hilo_t   hilo;

	// expected outputs in flight, plus which hi/lo entries are real instructions
	gpr_wr_t wb_q[$];
	hilo_t   hilo_q[$];
	bit      real_q[$];
	hilo_t   model_hilo;
	int      pending;

	tb_clock tb_clock_i (
		.clk (clk)
	);

	exec_top exec_top_i (
		.clk     (clk),
		.reset_n (reset_n),
		.id      (id),
		.wb      (wb),
		.hilo    (hilo)
	);

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at time %0t: %s actual %h expected %h",
				$time, name, actual, expected);
			$display("FAIL: see errors above");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("FAIL: see errors above");
		$fatal(1, "wait timed out");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	// half full random words, half edge values
	function automatic logic [31:0] random_operand();
		if ($urandom_range(0, 1) == 0) begin
			return $urandom;
		end
		case ($urandom_range(0, 5))
			0: return 32'h0000_0000;
			1: return 32'hffff_ffff;
			2: return 32'h8000_0000;
			3: return 32'h7fff_ffff;
			4: return 32'h0000_0001;
			default: return 32'($urandom_range(0, 31));
		endcase
	endfunction

	function automatic id_ex_t random_instr();
		id_ex_t      instr;
		int unsigned pick;
		pick = $urandom_range(0, 27);
		instr.reg1 = random_operand();
		instr.reg2 = random_operand();
		instr.waddr = 5'($urandom_range(0, 31));
		instr.we = ($urandom_range(0, 3) != 0);
		if (pick > 24) begin
			// bubble
			instr.alusel = SEL_NOP;
			instr.aluop = 8'($urandom);
			instr.we = 1'b0;
			return instr;
		end
		instr.aluop = OP_TABLE[pick];
		if (pick < 5) begin
			instr.alusel = SEL_LOGIC;
		end else if (pick < 8) begin
			instr.alusel = SEL_SHIFT;
		end else if (pick < 14) begin
			instr.alusel = SEL_MOVE;
		end else begin
			instr.alusel = SEL_ARITH;
		end
		// hi/lo writers never target a general register
		if (instr.aluop == OP_MTHI || instr.aluop == OP_MTLO ||
				instr.aluop == OP_MULT || instr.aluop == OP_MULTU) begin
			instr.we = 1'b0;
		end
		return instr;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic int unsigned lead_bits(input logic [31:0] word, input logic ones);
		int unsigned n;
		n = 0;
		while (n < 32 && word[31 - n] == ones) begin
			n++;
		end
		return n;
	endfunction

	// vacated bits fill with zero or with the sign bit for sra
	function automatic logic [31:0] shifted_word(input logic [7:0] op,
			input logic [31:0] data, input int amount);
		logic [31:0] res;
		for (int i = 0; i < 32; i++) begin
			if (op == OP_SLL) begin
				res[i] = (i >= amount) ? data[i - amount] : 1'b0;
			end else if (i + amount < 32) begin
				res[i] = data[i + amount];
			end else begin
				res[i] = (op == OP_SRA) ? data[31] : 1'b0;
			end
		end
		return res;
	endfunction

	function automatic gpr_wr_t expected_gpr(input id_ex_t instr, input hilo_t hl);
		gpr_wr_t res;
		longint  wide;
		res.we = instr.we;
		res.waddr = instr.waddr;
		res.wdata = '0;
		if (instr.alusel == SEL_NOP) begin
			return res;
		end
		case (instr.aluop)
			OP_AND:  res.wdata = instr.reg1 & instr.reg2;
			OP_OR:   res.wdata = instr.reg1 | instr.reg2;
			OP_XOR:  res.wdata = instr.reg1 ^ instr.reg2;
			OP_NOR:  res.wdata = ~instr.reg1 & ~instr.reg2;
			OP_LUI:  res.wdata = instr.reg2 << 16;
			OP_SLL, OP_SRL, OP_SRA: begin
				res.wdata = shifted_word(instr.aluop, instr.reg2, int'(instr.reg1[4:0]));
			end
			OP_MOVZ: begin
				res.wdata = instr.reg1;
				res.we = instr.we && (instr.reg2 == 32'd0);
			end
			OP_MOVN: begin
				res.wdata = instr.reg1;
				res.we = instr.we && (instr.reg2 != 32'd0);
			end
			OP_MFHI: res.wdata = hl.hi;
			OP_MFLO: res.wdata = hl.lo;
			OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
				if (instr.aluop == OP_ADD || instr.aluop == OP_ADDU) begin
					wide = longint'($signed(instr.reg1)) + longint'($signed(instr.reg2));
				end else begin
					wide = longint'($signed(instr.reg1)) - longint'($signed(instr.reg2));
				end
				res.wdata = wide[31:0];
				// signed result must survive a round trip through 32 bits
				if ((instr.aluop == OP_ADD || instr.aluop == OP_SUB) &&
						wide != longint'($signed(wide[31:0]))) begin
					res.we = 1'b0;
				end
			end
			OP_SLT:  res.wdata = ($signed(instr.reg1) < $signed(instr.reg2)) ? 32'd1 : 32'd0;
			OP_SLTU: res.wdata = (instr.reg1 < instr.reg2) ? 32'd1 : 32'd0;
			OP_CLZ:  res.wdata = 32'(lead_bits(instr.reg1, 1'b0));
			OP_CLO:  res.wdata = 32'(lead_bits(instr.reg1, 1'b1));
			OP_MUL: begin
				wide = longint'($signed(instr.reg1)) * longint'($signed(instr.reg2));
				res.wdata = wide[31:0];
			end
			default: res.wdata = '0;
		endcase
		return res;
	endfunction

	// hi/lo in program order
	function automatic hilo_t next_hilo(input id_ex_t instr, input hilo_t hl);
		longint      sprod;
		logic [63:0] uprod;
		if (instr.alusel == SEL_MOVE && instr.aluop == OP_MTHI) begin
			hl.hi = instr.reg1;
		end else if (instr.alusel == SEL_MOVE && instr.aluop == OP_MTLO) begin
			hl.lo = instr.reg1;
		end else if (instr.alusel == SEL_ARITH && instr.aluop == OP_MULT) begin
			sprod = longint'($signed(instr.reg1)) * longint'($signed(instr.reg2));
			hl = sprod;
		end else if (instr.alusel == SEL_ARITH && instr.aluop == OP_MULTU) begin
			uprod = 64'(instr.reg1) * 64'(instr.reg2);
			hl = uprod;
		end
		return hl;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// each cycle checks the outputs and then drives the next instruction
	////////////////////////////////////////////////////////////////////////////
	task automatic step(input id_ex_t instr, input bit is_real);
		gpr_wr_t exp_wb;
		hilo_t   exp_hilo;
		@(posedge clk);
		#DRIVE_DELAY;
		exp_wb = wb_q.pop_front();
		exp_hilo = hilo_q.pop_front();
		if (real_q.pop_front()) begin
			pending--;
		end
		check_value("wb.we", 64'(wb.we), 64'(exp_wb.we));
		if (exp_wb.we) begin
			check_value("wb.waddr", 64'(wb.waddr), 64'(exp_wb.waddr));
			check_value("wb.wdata", 64'(wb.wdata), 64'(exp_wb.wdata));
		end
		check_value("hilo", hilo, exp_hilo);
		id = instr;
		wb_q.push_back(expected_gpr(instr, model_hilo));
		model_hilo = next_hilo(instr, model_hilo);
		hilo_q.push_back(model_hilo);
		real_q.push_back(is_real);
		if (is_real) begin
			pending++;
		end
	endtask

	initial begin
		id_ex_t bubble;
		id_ex_t instr;
		int     waited;
		void'($urandom(32'h5c94_05af));
		bubble = '0;
		id = '0;
		reset_n = 1'b0;
		model_hilo = '0;
		pending = 0;
		// pipeline holds reset values until the first instructions arrive
		repeat (2) wb_q.push_back('0);
		repeat (3) begin
			hilo_q.push_back('0);
			real_q.push_back(1'b0);
		end

		for (int i = 0; i < RESET_CYCLES; i++) begin
			step(bubble, 1'b0);
			check_value("wb.wdata", 64'(wb.wdata), 64'd0);
		end
		reset_n = 1'b1;

		// idle and free of unknowns after reset
		waited = 0;
		do begin
			if (waited >= WAIT_LIMIT) begin
				report_timeout("the pipeline to come out of reset idle");
			end
			step(bubble, 1'b0);
			check_value("wb.wdata", 64'(wb.wdata), 64'd0);
			waited++;
		end while ($isunknown(wb) || $isunknown(hilo) || wb.we !== 1'b0);

		for (int n = 0; n < NUM_INSTR; n++) begin
			instr = random_instr();
			step(instr, instr.alusel != SEL_NOP);
		end

		// drain until the last hi/lo result has been compared
		waited = 0;
		while (pending > 0) begin
			if (waited >= WAIT_LIMIT) begin
				report_timeout("the pipeline to drain");
			end
			step(bubble, 1'b0);
			waited++;
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: vlog.f
src/cpu_pkg.sv
src/lead_count.sv
src/signed_mult.sv
src/ex_stage.sv
src/hilo_pipe.sv
src/exec_top.sv
bench/tb_clock.sv
bench/exec_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f vlog.f --top-module exec_tb -o exec_sim
	./obj_dir/exec_sim | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
